// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_soc_periph_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

# The run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== apb_bridge_fsm.sv ====
// Bridge FSM that turns four-phase host requests into APB transfers to the selected device
`timescale 1ns/1ps
`default_nettype none

module apb_bridge_fsm
    import soc_bus_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         req_i,
    input  wire                         we_i,
    input  wire apb_addr_u              addr_i,
    input  wire  [DATA_W-1:0]           wdata_i,
    output logic                        ack_o,
    output logic [DATA_W-1:0]           rdata_o,
    output logic                        err_o,
    output logic [DEV_COUNT-1:0]        psel_o,
    output logic                        penable_o,
    output apb_addr_u                   paddr_o,
    output logic                        pwrite_o,
    output logic [DATA_W-1:0]           pwdata_o,
    input  wire  [DEV_COUNT*DATA_W-1:0] prdata_i,
    input  wire  [DEV_COUNT-1:0]        pready_i,
    input  wire  [DEV_COUNT-1:0]        pslverr_i
);

    logic [STATE_W-1:0]   state_q;
    logic [STATE_W-1:0]   state_d;
    logic [DEV_COUNT-1:0] sel_q;      // One-hot, zero when unmapped
    logic [DEV_COUNT-1:0] dev_hit;
    apb_addr_u            addr_q;
    logic                 we_q;
    logic [DATA_W-1:0]    wdata_q;
    logic [DATA_W-1:0]    rd_mux;
    logic                 rd_ready;
    logic                 rd_err;
    logic                 start;

    assign start = (state_q == ST_IDLE) && req_i;

    // Device select from the dev field
    always_comb begin
        dev_hit = '0;
        for (int i = 0; i < DEV_COUNT; i++) begin
            if (addr_i.f.dev == DEV_W'(i)) begin
                dev_hit[i] = 1'b1;
            end
        end
    end

    // Response from the selected slave only
    always_comb begin
        rd_mux   = '0;
        rd_ready = 1'b0;
        rd_err   = 1'b0;
        for (int i = 0; i < DEV_COUNT; i++) begin
            if (sel_q[i]) begin
                rd_mux   = rd_mux | prdata_i[i*DATA_W +: DATA_W];
                rd_ready = rd_ready | pready_i[i];
                rd_err   = rd_err | pslverr_i[i];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    state_d = ST_SETUP;
                end
            end
            ST_SETUP:  state_d = (sel_q == '0) ? ST_RESP : ST_ACCESS;
            ST_ACCESS: begin
                if (rd_ready) begin
                    state_d = ST_RESP;
                end
            end
            ST_RESP: begin
                if (!req_i) begin   // Hold ack until host lets go
                    state_d = ST_DONE;
                end
            end
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            sel_q   <= '0;
            rdata_o <= '0;
            err_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start) begin
                sel_q <= dev_hit;
            end
            if ((state_q == ST_SETUP) && (sel_q == '0)) begin
                rdata_o <= '0;
                err_o   <= 1'b1;    // Unmapped device
            end else if ((state_q == ST_ACCESS) && rd_ready) begin
                rdata_o <= rd_err ? '0 : rd_mux;
                err_o   <= rd_err;
            end
        end
    end

    // Request payload captured at start
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr_i;
            we_q    <= we_i;
            wdata_q <= wdata_i;
        end
    end

    assign ack_o     = (state_q == ST_RESP);
    assign penable_o = (state_q == ST_ACCESS);
    assign psel_o    = ((state_q == ST_SETUP) || (state_q == ST_ACCESS)) ? sel_q : '0;
    assign paddr_o   = addr_q;
    assign pwrite_o  = we_q;
    assign pwdata_o  = wdata_q;

    a_penable_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        penable_o |-> (psel_o != '0));

    // Ack only answers a request still held on the edge that raised it
    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i));

endmodule

`default_nettype wire

// ==== apb_gpio.sv ====
// APB GPIO slave with output and direction registers, input sync and rising-edge events
`timescale 1ns/1ps
`default_nettype none

module apb_gpio
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire                psel_i,
    input  wire                penable_i,
    input  wire apb_addr_u     paddr_i,
    input  wire                pwrite_i,
    input  wire  [DATA_W-1:0]  pwdata_i,
    output logic [DATA_W-1:0]  prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    input  wire  [GPIO_W-1:0]  gpio_in_i,
    output logic [GPIO_W-1:0]  gpio_out_o,
    output logic [GPIO_W-1:0]  gpio_dir_o,
    output logic               edge_o
);

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] dir_q;
    logic [GPIO_W-1:0] inten_q;
    logic [GPIO_W-1:0] meta_q;     // First sync stage
    logic [GPIO_W-1:0] sync_q;
    logic [GPIO_W-1:0] prev_q;
    logic              edge_q;
    logic              access;
    logic              acc_err;
    logic              wr_en;
    logic [DATA_W-1:0] rd_val;

    assign access = psel_i & penable_i;

    always_comb begin
        acc_err = 1'b0;
        rd_val  = '0;
        case (paddr_i.f.reg_idx)
            GPIO_OUT:   rd_val = DATA_W'(out_q);
            GPIO_DIR:   rd_val = DATA_W'(dir_q);
            GPIO_IN: begin
                rd_val  = DATA_W'(sync_q);
                acc_err = pwrite_i;
            end
            GPIO_INTEN: rd_val = DATA_W'(inten_q);
            default:    acc_err = 1'b1;
        endcase
    end

    assign pready_o  = access;
    assign pslverr_o = access & acc_err;
    assign prdata_o  = (access && !acc_err && !pwrite_i) ? rd_val : '0;
    assign wr_en     = access & pwrite_i & ~acc_err;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            dir_q   <= '0;
            inten_q <= '0;
        end else if (wr_en) begin
            case (paddr_i.f.reg_idx)
                GPIO_OUT:   out_q   <= pwdata_i[GPIO_W-1:0];
                GPIO_DIR:   dir_q   <= pwdata_i[GPIO_W-1:0];
                GPIO_INTEN: inten_q <= pwdata_i[GPIO_W-1:0];
                default:    out_q   <= out_q;
            endcase
        end
    end

    // Two-flop sync, then rise detect on enabled pins
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
            edge_q <= 1'b0;
        end else begin
            meta_q <= gpio_in_i;
            sync_q <= meta_q;
            prev_q <= sync_q;
            edge_q <= |(sync_q & ~prev_q & inten_q);
        end
    end

    assign edge_o     = edge_q;
    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;

endmodule

`default_nettype wire

// ==== apb_timer.sv ====
// APB timer slave with period wrap, a one-cycle wrap event and a compare PWM output
`timescale 1ns/1ps
`default_nettype none

module apb_timer
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire                psel_i,
    input  wire                penable_i,
    input  wire apb_addr_u     paddr_i,
    input  wire                pwrite_i,
    input  wire  [DATA_W-1:0]  pwdata_i,
    output logic [DATA_W-1:0]  prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               wrap_o,
    output logic               ch_o
);

    logic               en_q;
    logic [TIMER_W-1:0] period_q;
    logic [TIMER_W-1:0] cmp_q;
    logic [TIMER_W-1:0] count_q;
    logic               access;
    logic               acc_err;
    logic               wr_en;
    logic               restart;
    logic [DATA_W-1:0]  rd_val;

    assign access = psel_i & penable_i;

    always_comb begin
        acc_err = 1'b0;
        rd_val  = '0;
        case (paddr_i.f.reg_idx)
            TMR_CTRL:   rd_val = DATA_W'(en_q);
            TMR_PERIOD: rd_val = DATA_W'(period_q);
            TMR_CMP:    rd_val = DATA_W'(cmp_q);
            TMR_COUNT: begin
                rd_val  = DATA_W'(count_q);
                acc_err = pwrite_i;   // Count is read-only
            end
            default:    acc_err = 1'b1;
        endcase
    end

    assign pready_o  = access;   // Zero wait states
    assign pslverr_o = access & acc_err;
    assign prdata_o  = (access && !acc_err && !pwrite_i) ? rd_val : '0;
    assign wr_en     = access & pwrite_i & ~acc_err;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            en_q     <= 1'b0;
            period_q <= '0;
            cmp_q    <= '0;
        end else if (wr_en) begin
            case (paddr_i.f.reg_idx)
                TMR_CTRL:   en_q     <= pwdata_i[TMR_EN_BIT];
                TMR_PERIOD: period_q <= pwdata_i[TIMER_W-1:0];
                TMR_CMP:    cmp_q    <= pwdata_i[TIMER_W-1:0];
                default:    en_q     <= en_q;
            endcase
        end
    end

    // Enabling or a new period starts counting from zero
    assign restart = wr_en && (((paddr_i.f.reg_idx == TMR_CTRL) && pwdata_i[TMR_EN_BIT])
                               || (paddr_i.f.reg_idx == TMR_PERIOD));

    assign wrap_o = en_q && (count_q == period_q);

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart || wrap_o) begin
            count_q <= '0;
        end else if (en_q) begin
            count_q <= count_q + TIMER_W'(1);
        end
    end

    assign ch_o = en_q && (count_q < cmp_q);   // PWM level

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        en_q |-> (count_q <= period_q));

endmodule

`default_nettype wire

// ==== irq_ctrl.sv ====
// Interrupt controller slave holding pending and enable bits and driving the merged IRQ line
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire                psel_i,
    input  wire                penable_i,
    input  wire apb_addr_u     paddr_i,
    input  wire                pwrite_i,
    input  wire  [DATA_W-1:0]  pwdata_i,
    output logic [DATA_W-1:0]  prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    input  wire  [IRQ_W-1:0]   src_i,
    output logic               irq_o
);

    logic [IRQ_W-1:0]  pend_q;
    logic [IRQ_W-1:0]  en_q;
    logic [IRQ_W-1:0]  pend_clr;
    logic              access;
    logic              acc_err;
    logic              wr_en;
    logic [DATA_W-1:0] rd_val;

    assign access = psel_i & penable_i;

    always_comb begin
        acc_err = 1'b0;
        rd_val  = '0;
        case (paddr_i.f.reg_idx)
            IRQ_PEND: rd_val = DATA_W'(pend_q);
            IRQ_EN:   rd_val = DATA_W'(en_q);
            default:  acc_err = 1'b1;
        endcase
    end

    assign pready_o  = access;
    assign pslverr_o = access & acc_err;
    assign prdata_o  = (access && !acc_err && !pwrite_i) ? rd_val : '0;
    assign wr_en     = access & pwrite_i & ~acc_err;

    assign pend_clr = (wr_en && (paddr_i.f.reg_idx == IRQ_PEND)) ? pwdata_i[IRQ_W-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pend_q <= '0;
            en_q   <= '0;
        end else begin
            pend_q <= (pend_q & ~pend_clr) | src_i;   // New event beats a clear
            if (wr_en && (paddr_i.f.reg_idx == IRQ_EN)) begin
                en_q <= pwdata_i[IRQ_W-1:0];
            end
        end
    end

    assign irq_o = |(pend_q & en_q);

    a_irq_masked: assert property (@(posedge clk) disable iff (!rst_n_i)
        (en_q == '0) |-> !irq_o);

endmodule

`default_nettype wire

// ==== soc_bus_pkg.sv ====
// Bus widths, APB device map, address union and bridge state codes shared by bridge and slaves
`default_nettype none

package soc_bus_pkg;

    localparam int ADDR_W    = 12;
    localparam int DATA_W    = 32;
    localparam int DEV_COUNT = 3;

    // Address field widths, dev sits in bits 11:8
    localparam int DEV_W     = 4;
    localparam int REG_IDX_W = 6;
    localparam int BYTE_W    = 2;

    // Device map, index equals psel bit
    localparam int DEV_TIMER = 0;
    localparam int DEV_GPIO  = 1;
    localparam int DEV_IRQ   = 2;

    // Bridge FSM state codes
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_IDLE   = 3'd0;
    localparam logic [STATE_W-1:0] ST_SETUP  = 3'd1;
    localparam logic [STATE_W-1:0] ST_ACCESS = 3'd2;
    localparam logic [STATE_W-1:0] ST_RESP   = 3'd3;
    localparam logic [STATE_W-1:0] ST_DONE   = 3'd4;

    // Bridge decodes dev, slaves decode reg_idx
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [DEV_W-1:0]     dev;
            logic [REG_IDX_W-1:0] reg_idx;   // Word offset inside a device
            logic [BYTE_W-1:0]    byte_off;
        } f;
    } apb_addr_u;

endpackage

`default_nettype wire

// ==== soc_periph_pkg.sv ====
// Register word indices, peripheral widths and interrupt source bits used by the APB peripherals
`default_nettype none

package soc_periph_pkg;

    import soc_bus_pkg::REG_IDX_W;

    localparam int TIMER_W = 16;   // Counter width
    localparam int GPIO_W  = 8;    // Pin count
    localparam int IRQ_W   = 2;    // Interrupt sources

    // Source bits inside PEND and EN
    localparam int IRQ_TIMER = 0;
    localparam int IRQ_GPIO  = 1;

    // Timer registers
    localparam logic [REG_IDX_W-1:0] TMR_CTRL   = 6'd0;
    localparam logic [REG_IDX_W-1:0] TMR_PERIOD = 6'd1;
    localparam logic [REG_IDX_W-1:0] TMR_CMP    = 6'd2;
    localparam logic [REG_IDX_W-1:0] TMR_COUNT  = 6'd3;   // Read-only
    localparam int TMR_EN_BIT = 0;

    // GPIO registers
    localparam logic [REG_IDX_W-1:0] GPIO_OUT   = 6'd0;
    localparam logic [REG_IDX_W-1:0] GPIO_DIR   = 6'd1;
    localparam logic [REG_IDX_W-1:0] GPIO_IN    = 6'd2;   // Read-only
    localparam logic [REG_IDX_W-1:0] GPIO_INTEN = 6'd3;

    // Interrupt controller registers
    localparam logic [REG_IDX_W-1:0] IRQ_PEND = 6'd0;     // Write 1 to clear
    localparam logic [REG_IDX_W-1:0] IRQ_EN   = 6'd1;

endpackage

`default_nettype wire

// ==== soc_periph_top.sv ====
// Subsystem top that wires the host bridge to the timer, GPIO and interrupt controller over APB
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n_i,
    input  wire               req_i,
    input  wire               we_i,
    input  wire apb_addr_u    addr_i,
    input  wire [DATA_W-1:0]  wdata_i,
    output wire               ack_o,
    output wire [DATA_W-1:0]  rdata_o,
    output wire               err_o,
    output wire               irq_o,
    output wire               ch_o,
    input  wire [GPIO_W-1:0]  gpio_in_i,
    output wire [GPIO_W-1:0]  gpio_out_o,
    output wire [GPIO_W-1:0]  gpio_dir_o
);

    // APB fabric
    wire [DEV_COUNT-1:0]        psel;
    wire                        penable;
    wire apb_addr_u             paddr;
    wire                        pwrite;
    wire [DATA_W-1:0]           pwdata;
    wire [DEV_COUNT*DATA_W-1:0] prdata;
    wire [DEV_COUNT-1:0]        pready;
    wire [DEV_COUNT-1:0]        pslverr;
    wire [IRQ_W-1:0]            irq_src;   // Wrap and edge pulses

    apb_bridge_fsm u_bridge (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .err_o     (err_o),
        .psel_o    (psel),
        .penable_o (penable),
        .paddr_o   (paddr),
        .pwrite_o  (pwrite),
        .pwdata_o  (pwdata),
        .prdata_i  (prdata),
        .pready_i  (pready),
        .pslverr_i (pslverr)
    );

    apb_timer u_timer (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel[DEV_TIMER]),
        .penable_i (penable),
        .paddr_i   (paddr),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata[DEV_TIMER*DATA_W +: DATA_W]),
        .pready_o  (pready[DEV_TIMER]),
        .pslverr_o (pslverr[DEV_TIMER]),
        .wrap_o    (irq_src[IRQ_TIMER]),
        .ch_o      (ch_o)
    );

    apb_gpio u_gpio (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel[DEV_GPIO]),
        .penable_i  (penable),
        .paddr_i    (paddr),
        .pwrite_i   (pwrite),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata[DEV_GPIO*DATA_W +: DATA_W]),
        .pready_o   (pready[DEV_GPIO]),
        .pslverr_o  (pslverr[DEV_GPIO]),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_dir_o (gpio_dir_o),
        .edge_o     (irq_src[IRQ_GPIO])
    );

    irq_ctrl u_irq (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel[DEV_IRQ]),
        .penable_i (penable),
        .paddr_i   (paddr),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata[DEV_IRQ*DATA_W +: DATA_W]),
        .pready_o  (pready[DEV_IRQ]),
        .pslverr_o (pslverr[DEV_IRQ]),
        .src_i     (irq_src),
        .irq_o     (irq_o)
    );

endmodule

`default_nettype wire

// ==== tb_soc_periph_top.sv ====
// Self-checking testbench for the peripheral subsystem, run as the simulation top with the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph_top
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int HS_LIMIT     = 20;   // Cycles allowed for each handshake phase
    // Cycle budget per test from access count, holds and timer periods
    localparam int T1_CYCLES = 400;
    localparam int T2_CYCLES = 400;
    localparam int T3_CYCLES = 400;
    localparam int T4_CYCLES = 300;
    localparam int T5_CYCLES = 300;
    localparam int MARGIN_CYCLES   = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                     + T4_CYCLES + T5_CYCLES + MARGIN_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              we;
    apb_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic              irq;
    logic              ch;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic [GPIO_W-1:0] gpio_dir;

    // Shadow of the register state
    logic               sh_tmr_en;
    logic [TIMER_W-1:0] sh_period;
    logic [TIMER_W-1:0] sh_cmp;
    logic [GPIO_W-1:0]  sh_out;
    logic [GPIO_W-1:0]  sh_dir;
    logic [GPIO_W-1:0]  sh_inten;
    logic [GPIO_W-1:0]  sh_gpio_in;
    logic [IRQ_W-1:0]   sh_pend;
    logic [IRQ_W-1:0]   sh_en;

    logic [DATA_W:0] exp_q[$];   // {err, data} per completed access
    logic [DATA_W:0] act_q[$];

    integer seed = 32'h20dc2ff7;
    int     error_count = 0;
    int     check_count = 0;
    int     test_num = 0;
    int     tests_failed = 0;
    int     errs_at_start = 0;

    soc_periph_top uut (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .req_i      (req),
        .we_i       (we),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .ack_o      (ack),
        .rdata_o    (rdata),
        .err_o      (err),
        .irq_o      (irq),
        .ch_o       (ch),
        .gpio_in_i  (gpio_in),
        .gpio_out_o (gpio_out),
        .gpio_dir_o (gpio_dir)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // Expected {err, rdata} of an access under the register rules
    function automatic logic [DATA_W:0] ref_read(input logic wr, input apb_addr_u a);
        logic [DATA_W-1:0] d;
        logic              e;
        d = '0;
        e = 1'b0;
        case (a.f.dev)
            DEV_W'(DEV_TIMER): begin
                case (a.f.reg_idx)
                    TMR_CTRL:   d = DATA_W'(sh_tmr_en);
                    TMR_PERIOD: d = DATA_W'(sh_period);
                    TMR_CMP:    d = DATA_W'(sh_cmp);
                    TMR_COUNT:  e = wr;   // Read only while stopped and cleared
                    default:    e = 1'b1;
                endcase
            end
            DEV_W'(DEV_GPIO): begin
                case (a.f.reg_idx)
                    GPIO_OUT:   d = DATA_W'(sh_out);
                    GPIO_DIR:   d = DATA_W'(sh_dir);
                    GPIO_IN: begin
                        d = DATA_W'(sh_gpio_in);
                        e = wr;
                    end
                    GPIO_INTEN: d = DATA_W'(sh_inten);
                    default:    e = 1'b1;
                endcase
            end
            DEV_W'(DEV_IRQ): begin
                case (a.f.reg_idx)
                    IRQ_PEND: d = DATA_W'(sh_pend);
                    IRQ_EN:   d = DATA_W'(sh_en);
                    default:  e = 1'b1;
                endcase
            end
            default: e = 1'b1;   // No slave behind dev 3 and up
        endcase
        if (wr || e) begin
            d = '0;
        end
        return {e, d};
    endfunction

    task automatic update_shadow(input apb_addr_u a, input logic [DATA_W-1:0] d);
        case (a.f.dev)
            DEV_W'(DEV_TIMER): begin
                if (a.f.reg_idx == TMR_CTRL) sh_tmr_en = d[TMR_EN_BIT];
                if (a.f.reg_idx == TMR_PERIOD) sh_period = d[TIMER_W-1:0];
                if (a.f.reg_idx == TMR_CMP) sh_cmp = d[TIMER_W-1:0];
            end
            DEV_W'(DEV_GPIO): begin
                if (a.f.reg_idx == GPIO_OUT) sh_out = d[GPIO_W-1:0];
                if (a.f.reg_idx == GPIO_DIR) sh_dir = d[GPIO_W-1:0];
                if (a.f.reg_idx == GPIO_INTEN) sh_inten = d[GPIO_W-1:0];
            end
            DEV_W'(DEV_IRQ): begin
                if (a.f.reg_idx == IRQ_PEND) sh_pend = sh_pend & ~d[IRQ_W-1:0];
                if (a.f.reg_idx == IRQ_EN) sh_en = d[IRQ_W-1:0];
            end
            default: ;
        endcase
    endtask

    task automatic check_val(input string name, input logic [DATA_W-1:0] exp_v,
                             input logic [DATA_W-1:0] act_v);
        check_count++;
        assert (act_v == exp_v) else begin
            $display("FAIL t=%0t %s: expected %0h, actual %0h", $time, name, exp_v, act_v);
            error_count++;
        end
    endtask

    task automatic check_irq();
        check_val("irq_o", DATA_W'(|(sh_pend & sh_en)), DATA_W'(irq));
    endtask

    // Four-phase host access with req_i held for extra cycles after ack
    task automatic do_access(input logic wr, input int dev, input logic [REG_IDX_W-1:0] ridx,
                             input logic [DATA_W-1:0] data, input int hold);
        logic [DATA_W:0] expv;
        int              waited;
        @(posedge clk);
        #1;
        addr.f.dev      = DEV_W'(dev);
        addr.f.reg_idx  = ridx;
        addr.f.byte_off = '0;
        we    = wr;
        wdata = data;
        req   = 1'b1;
        expv  = ref_read(wr, addr);
        waited = 0;
        while (!ack && waited < HS_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ack) begin
            $display("ERROR t=%0t: no ack_o within %0d cycles of req_i", $time, HS_LIMIT);
            error_count++;
            req = 1'b0;
            return;
        end
        exp_q.push_back(expv);
        act_q.push_back({err, rdata});
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_val("ack_o", DATA_W'(1'b1), DATA_W'(ack));   // Back-pressure
        end
        req = 1'b0;
        waited = 0;
        while (ack && waited < HS_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (ack) begin
            $display("ERROR t=%0t: ack_o stayed high after req_i dropped", $time);
            error_count++;
        end
        if (wr && !expv[DATA_W]) begin
            update_shadow(addr, data);
        end
    endtask

    task automatic do_write(input int dev, input logic [REG_IDX_W-1:0] ridx,
                            input logic [DATA_W-1:0] data, input int hold);
        do_access(1'b1, dev, ridx, data, hold);
    endtask

    task automatic do_read(input int dev, input logic [REG_IDX_W-1:0] ridx, input int hold);
        do_access(1'b0, dev, ridx, '0, hold);
    endtask

    task automatic settle_gpio();
        repeat (6) @(posedge clk);   // Sync, edge and pending stages
        #1;
    endtask

    task automatic finish_test(input string name);
        wait (act_q.size() == 0);
        test_num++;
        if (error_count == errs_at_start) begin
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_num, name, error_count - errs_at_start);
            tests_failed++;
        end
        errs_at_start = error_count;
    endtask

    // Compares each completed access with its reference
    always begin
        logic [DATA_W:0] e_v;
        logic [DATA_W:0] a_v;
        wait (act_q.size() > 0);
        e_v = exp_q.pop_front();
        a_v = act_q.pop_front();
        check_val("err_o", DATA_W'(e_v[DATA_W]), DATA_W'(a_v[DATA_W]));
        check_val("rdata_o", e_v[DATA_W-1:0], a_v[DATA_W-1:0]);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          p_val;
        int          c_val;
        int          hi;
        int          waited;
        logic        prev;
        int          en_pin;
        int          dis_pin;
        rst_n = 1'b0;
        req = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        gpio_in = '0;
        {sh_tmr_en, sh_period, sh_cmp} = '0;
        {sh_out, sh_dir, sh_inten, sh_gpio_in, sh_pend, sh_en} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Test 1 reset values and register readback
        check_val("ack_o", '0, DATA_W'(ack));
        check_val("err_o", '0, DATA_W'(err));
        check_val("irq_o", '0, DATA_W'(irq));
        check_val("ch_o", '0, DATA_W'(ch));
        check_val("gpio_out_o", '0, DATA_W'(gpio_out));
        check_val("gpio_dir_o", '0, DATA_W'(gpio_dir));
        do_write(DEV_TIMER, TMR_PERIOD, next_rand(), 0);
        do_write(DEV_TIMER, TMR_CMP, next_rand(), 0);
        do_write(DEV_GPIO, GPIO_OUT, next_rand(), 0);
        do_write(DEV_GPIO, GPIO_DIR, next_rand(), 0);
        do_write(DEV_GPIO, GPIO_INTEN, next_rand(), 0);
        do_write(DEV_IRQ, IRQ_EN, next_rand(), 0);
        do_read(DEV_TIMER, TMR_CTRL, 0);
        do_read(DEV_TIMER, TMR_PERIOD, 0);
        do_read(DEV_TIMER, TMR_CMP, 0);
        do_read(DEV_TIMER, TMR_COUNT, 0);
        do_read(DEV_GPIO, GPIO_OUT, 0);
        do_read(DEV_GPIO, GPIO_DIR, 0);
        do_read(DEV_GPIO, GPIO_INTEN, 0);
        do_read(DEV_IRQ, IRQ_EN, 0);
        do_read(DEV_IRQ, IRQ_PEND, 0);
        check_val("gpio_out_o", DATA_W'(sh_out), DATA_W'(gpio_out));
        check_val("gpio_dir_o", DATA_W'(sh_dir), DATA_W'(gpio_dir));
        finish_test("register readback");

        // Test 2 error responses with random ack hold
        r = next_rand();
        do_read(DEV_TIMER, REG_IDX_W'(4 + int'(r[5:0]) % 60), int'(r[8:6]));
        r = next_rand();
        do_read(DEV_GPIO, REG_IDX_W'(4 + int'(r[5:0]) % 60), int'(r[8:6]));
        r = next_rand();
        do_read(DEV_IRQ, REG_IDX_W'(2 + int'(r[5:0]) % 62), int'(r[8:6]));
        r = next_rand();
        do_write(DEV_TIMER, TMR_COUNT, next_rand(), int'(r[2:0]));
        do_write(DEV_GPIO, GPIO_IN, next_rand(), int'(r[5:3]));
        r = next_rand();
        do_read(3, REG_IDX_W'(r[5:0]), int'(r[8:6]));
        do_write(3, REG_IDX_W'(r[14:9]), next_rand(), int'(r[17:15]));
        do_read(3 + int'(r[23:20]) % 13, TMR_CTRL, int'(r[26:24]));
        finish_test("error responses");

        // Test 3 PWM duty and timer interrupt
        r = next_rand();
        p_val = 4 + int'(r[4:0]);
        c_val = 1 + int'(r[20:5]) % p_val;
        do_write(DEV_TIMER, TMR_PERIOD, DATA_W'(p_val), 0);
        do_write(DEV_TIMER, TMR_CMP, DATA_W'(c_val), 0);
        do_write(DEV_TIMER, TMR_CTRL, DATA_W'(1), 0);
        prev = ch;
        waited = 0;
        while (!(!prev && ch) && waited < 2 * (p_val + 1) + 10) begin
            prev = ch;
            @(posedge clk);
            #1;
            waited++;
        end
        assert (!prev && ch) else begin
            $display("ERROR t=%0t: ch_o never rose with the timer enabled", $time);
            error_count++;
        end
        hi = 0;
        for (int i = 0; i <= p_val; i++) begin
            if (ch) hi++;
            @(posedge clk);
            #1;
        end
        check_val("ch_o high cycles", DATA_W'(c_val), DATA_W'(hi));
        sh_pend[IRQ_TIMER] = 1'b1;   // A full period implies a wrap
        do_write(DEV_TIMER, TMR_CTRL, '0, 0);
        do_read(DEV_TIMER, TMR_CTRL, 0);
        do_read(DEV_IRQ, IRQ_PEND, 0);
        check_irq();
        do_write(DEV_IRQ, IRQ_PEND, DATA_W'(1 << IRQ_TIMER), 0);
        do_read(DEV_IRQ, IRQ_PEND, 0);
        check_irq();
        finish_test("timer pwm");

        // Test 4 GPIO input and edge interrupt
        r = next_rand();
        en_pin = int'(r[2:0]);
        dis_pin = (en_pin + 1 + int'(r[5:3]) % 7) % 8;
        do_write(DEV_GPIO, GPIO_INTEN, DATA_W'(1 << en_pin), 0);
        gpio_in = GPIO_W'(1 << dis_pin);
        settle_gpio();
        sh_gpio_in = gpio_in;
        do_read(DEV_GPIO, GPIO_IN, 0);
        do_read(DEV_IRQ, IRQ_PEND, 0);    // Masked pin leaves PEND alone
        gpio_in = gpio_in | GPIO_W'(1 << en_pin);
        settle_gpio();
        sh_gpio_in = gpio_in;
        sh_pend[IRQ_GPIO] = 1'b1;
        do_read(DEV_GPIO, GPIO_IN, 0);
        do_read(DEV_IRQ, IRQ_PEND, 0);
        check_irq();
        finish_test("gpio edge");

        // Test 5 interrupt masking and clear
        do_write(DEV_IRQ, IRQ_EN, '0, 0);
        check_irq();
        do_write(DEV_IRQ, IRQ_EN, DATA_W'(2'b11), 0);
        check_irq();
        do_write(DEV_IRQ, IRQ_PEND, DATA_W'(1 << IRQ_GPIO), 0);
        check_irq();
        do_read(DEV_IRQ, IRQ_PEND, 0);
        do_read(DEV_IRQ, IRQ_EN, 0);
        finish_test("irq mask and clear");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
soc_bus_pkg.sv
soc_periph_pkg.sv
apb_bridge_fsm.sv
apb_timer.sv
apb_gpio.sv
irq_ctrl.sv
soc_periph_top.sv
tb_soc_periph_top.sv
